// File: Makefile
TOP = tb_i3c_tx

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
logic/i3c_timing_pkg.sv
logic/i3c_tx_pkg.sv
logic/tx_bit_if.sv
logic/scl_event_detect.sv
logic/bus_tx_flow.sv
logic/bus_tx.sv
logic/i3c_tx_top.sv
verification/i3c_tx_assertions.sv
verification/tx_checker.sv
verification/tb_i3c_tx.sv

// File: logic/bus_tx.sv
// SDA bit driver
`timescale 1ns/1ns
`default_nettype none

module bus_tx (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     scl_negedge_i,
  input  logic     scl_posedge_i,
  input  logic     scl_stable_low_i,
  tx_bit_if.driver tx,
  output logic     sda_o,
  output logic     sel_od_pp_o
);
  i3c_tx_pkg::drv_state_e state_q, state_d;

  logic [i3c_timing_pkg::TIMING_CNT_W-1:0] cnt_q, cnt_d;
  logic latch;
  logic load;
  logic released;
  // Bit captured at the SCL fall
  logic pend_drive_q;
  logic pend_value_q;
  logic pend_mode_q;

  assign released   = sda_o & ~sel_od_pp_o;
  assign tx.tx_idle = (state_q == i3c_tx_pkg::DRV_IDLE);

  always_comb begin : drv_fsm
    state_d      = state_q;
    cnt_d        = cnt_q + 1'b1;
    latch        = 1'b0;
    load         = 1'b0;
    tx.tx_done   = 1'b0;
    tx.setup_err = 1'b0;

    unique case (state_q)
      i3c_tx_pkg::DRV_IDLE: begin
        cnt_d = '0;
        // A fall also releases a line still held from the last bit
        if (scl_negedge_i && (tx.drive || !released)) begin
          latch   = 1'b1;
          state_d = i3c_tx_pkg::DRV_HOLD;
        end else if (scl_stable_low_i && tx.drive) begin
          latch   = 1'b1;
          state_d = i3c_tx_pkg::DRV_HOLD;
        end
      end
      i3c_tx_pkg::DRV_HOLD: begin
        if (scl_posedge_i) begin
          // Rise before the hold ended, bit counts but setup failed
          load         = 1'b1;
          tx.tx_done   = pend_drive_q;
          tx.setup_err = pend_drive_q;
          state_d      = i3c_tx_pkg::DRV_IDLE;
        end else if (32'(cnt_q) == i3c_timing_pkg::T_HD_DAT - 1) begin
          load    = 1'b1;
          // First setup cycle counts as one stable cycle
          cnt_d   = {{(i3c_timing_pkg::TIMING_CNT_W-1){1'b0}}, 1'b1};
          state_d = pend_drive_q ? i3c_tx_pkg::DRV_SETUP : i3c_tx_pkg::DRV_IDLE;
        end
      end
      i3c_tx_pkg::DRV_SETUP: begin
        if (scl_posedge_i) begin
          tx.tx_done   = 1'b1;
          tx.setup_err = 32'(cnt_q) < i3c_timing_pkg::T_SU_DAT + i3c_timing_pkg::T_R;
          state_d      = i3c_tx_pkg::DRV_IDLE;
        end else if (32'(cnt_q) >= i3c_timing_pkg::T_SU_DAT + i3c_timing_pkg::T_R) begin
          state_d = i3c_tx_pkg::DRV_WAIT_RISE;
        end
      end
      i3c_tx_pkg::DRV_WAIT_RISE: begin
        cnt_d = cnt_q;
        if (scl_posedge_i) begin
          tx.tx_done = 1'b1;
          state_d    = i3c_tx_pkg::DRV_IDLE;
        end
      end
      default: state_d = i3c_tx_pkg::DRV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : drv_state
    if (!rst_ni) begin
      state_q      <= i3c_tx_pkg::DRV_IDLE;
      cnt_q        <= '0;
      pend_drive_q <= 1'b0;
      sda_o        <= 1'b1;
      sel_od_pp_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (latch) pend_drive_q <= tx.drive;
      // Value and mode change together, released means 1 open drain
      if (load) begin
        sda_o       <= pend_drive_q ? pend_value_q : 1'b1;
        sel_od_pp_o <= pend_drive_q & pend_mode_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin : pend_bit
    if (latch) begin
      pend_value_q <= tx.drive_value;
      pend_mode_q  <= tx.sel_od_pp;
    end
  end
endmodule

`default_nettype wire

// File: logic/bus_tx_flow.sv
// Transmit request sequencer
`timescale 1ns/1ns
`default_nettype none

module bus_tx_flow (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Request handshake
  input  logic       req_byte_i,
  input  logic       req_bit_i,
  input  logic [7:0] req_value_i,
  input  logic       abort_i,
  input  logic       sel_od_pp_i,
  output logic       bus_tx_done_o,
  output logic       bus_tx_idle_o,
  output logic       req_error_o,
  output logic       bus_error_o,
  // Bit requests to the driver
  tx_bit_if.flow     tx
);
  i3c_tx_pkg::tx_state_e state_q, state_d;

  logic [i3c_tx_pkg::BIT_CNT_W-1:0] bit_cnt_q;
  logic [7:0]                       shift_q;
  logic                             req;
  logic                             load;
  logic                             first_value;

  assign req = req_byte_i | req_bit_i;

  // Only one request kind at a time
  assign req_error_o = req_byte_i & req_bit_i;

  // First bit straight from the request inputs
  assign first_value = req_byte_i ? req_value_i[7] : req_value_i[0];

  // Mode follows the requester only while a bit is driven
  assign tx.sel_od_pp = tx.drive & sel_od_pp_i;

  always_comb begin : flow_fsm
    state_d        = state_q;
    tx.drive       = 1'b0;
    // Released line by default
    tx.drive_value = 1'b1;
    bus_tx_done_o  = 1'b0;
    bus_tx_idle_o  = 1'b0;
    load           = 1'b0;

    unique case (state_q)
      i3c_tx_pkg::IDLE: begin
        bus_tx_idle_o = tx.tx_idle;
        if (tx.tx_idle && req) begin
          tx.drive       = 1'b1;
          tx.drive_value = first_value;
          load           = 1'b1;
          state_d        = req_byte_i ? i3c_tx_pkg::DRIVE_BYTE : i3c_tx_pkg::DRIVE_BIT;
        end
      end
      i3c_tx_pkg::DRIVE_BYTE: begin
        // MSB first out of the shift register
        tx.drive       = 1'b1;
        tx.drive_value = shift_q[7];
        if (tx.tx_done && (bit_cnt_q == '0)) begin
          bus_tx_done_o = 1'b1;
          state_d       = i3c_tx_pkg::NEXT_TASK;
        end
      end
      i3c_tx_pkg::DRIVE_BIT: begin
        tx.drive       = 1'b1;
        tx.drive_value = shift_q[0];
        if (tx.tx_done) begin
          bus_tx_done_o = 1'b1;
          state_d       = i3c_tx_pkg::NEXT_TASK;
        end
      end
      i3c_tx_pkg::NEXT_TASK: begin
        // Chain the next request, the driver latches it at the next fall
        if (req) begin
          tx.drive       = 1'b1;
          tx.drive_value = first_value;
          load           = 1'b1;
          state_d        = req_byte_i ? i3c_tx_pkg::DRIVE_BYTE : i3c_tx_pkg::DRIVE_BIT;
        end else begin
          state_d = i3c_tx_pkg::IDLE;
        end
      end
      default: state_d = i3c_tx_pkg::IDLE;
    endcase

    // Abort, dropped request or request error release the bus
    if (abort_i || !req || req_error_o) begin
      state_d        = i3c_tx_pkg::IDLE;
      tx.drive       = 1'b0;
      tx.drive_value = 1'b1;
      bus_tx_done_o  = 1'b0;
      load           = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : flow_state
    if (!rst_ni) begin
      state_q     <= i3c_tx_pkg::IDLE;
      bit_cnt_q   <= '0;
      bus_error_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      bus_error_o <= tx.setup_err;
      if (load) begin
        bit_cnt_q <= '1;
      end else if ((state_q == i3c_tx_pkg::DRIVE_BYTE) && tx.tx_done) begin
        bit_cnt_q <= bit_cnt_q - 1'b1;
      end
    end
  end

  // Shift one place per sampled bit
  always_ff @(posedge clk_i) begin : shift_reg
    if (load) begin
      shift_q <= req_value_i;
    end else if ((state_q == i3c_tx_pkg::DRIVE_BYTE) && tx.tx_done) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end
endmodule

`default_nettype wire

// File: logic/i3c_timing_pkg.sv
// I3C bus timing constants
`default_nettype none

package i3c_timing_pkg;

  // All values are in system clock cycles

  // Hold after a detected SCL fall before SDA may change
  localparam int unsigned T_HD_DAT = 3;

  // Minimum SDA stable time before SCL rises
  localparam int unsigned T_SU_DAT = 4;

  // Rise time allowance, added on top of setup
  localparam int unsigned T_R = 2;

  // SCL synchroniser depth
  localparam int unsigned SYNC_STAGES = 2;

  // Low cycles before SCL counts as stable low
  localparam int unsigned STABLE_LOW_CYCLES = 2;

  // Width of the timing counters
  localparam int unsigned TIMING_CNT_W = 8;

endpackage

`default_nettype wire

// File: logic/i3c_tx_pkg.sv
// I3C transmit types
`default_nettype none

package i3c_tx_pkg;

  // Flow stage FSM
  typedef enum logic [1:0] {
    IDLE,
    DRIVE_BYTE,
    DRIVE_BIT,
    NEXT_TASK
  } tx_state_e;

  // Bit driver FSM
  // DRV_IDLE also covers the SCL high phase between bits
  typedef enum logic [1:0] {
    DRV_IDLE,
    DRV_HOLD,
    DRV_SETUP,
    DRV_WAIT_RISE
  } drv_state_e;

  // Bit position counter within a byte
  localparam int unsigned BIT_CNT_W = 3;

endpackage

`default_nettype wire

// File: logic/i3c_tx_top.sv
// I3C transmit top level
`timescale 1ns/1ns
`default_nettype none

module i3c_tx_top (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       req_byte_i,
  input  logic       req_bit_i,
  input  logic [7:0] req_value_i,
  input  logic       abort_i,
  input  logic       sel_od_pp_i,
  output logic       bus_tx_done_o,
  output logic       bus_tx_idle_o,
  output logic       req_error_o,
  output logic       bus_error_o,
  output logic       sda_o,
  output logic       sel_od_pp_o
);
  // SCL events
  logic scl_negedge;
  logic scl_posedge;
  logic scl_stable_low;

  // Flow to driver link
  tx_bit_if tx_bit ();

  scl_event_detect scl_evt0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .scl_i            (scl_i),
    .scl_negedge_o    (scl_negedge),
    .scl_posedge_o    (scl_posedge),
    .scl_stable_low_o (scl_stable_low)
  );

  bus_tx_flow flow0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_byte_i    (req_byte_i),
    .req_bit_i     (req_bit_i),
    .req_value_i   (req_value_i),
    .abort_i       (abort_i),
    .sel_od_pp_i   (sel_od_pp_i),
    .bus_tx_done_o (bus_tx_done_o),
    .bus_tx_idle_o (bus_tx_idle_o),
    .req_error_o   (req_error_o),
    .bus_error_o   (bus_error_o),
    .tx            (tx_bit.flow)
  );

  bus_tx tx0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .scl_negedge_i    (scl_negedge),
    .scl_posedge_i    (scl_posedge),
    .scl_stable_low_i (scl_stable_low),
    .tx               (tx_bit.driver),
    .sda_o            (sda_o),
    .sel_od_pp_o      (sel_od_pp_o)
  );
endmodule

`default_nettype wire

// File: logic/scl_event_detect.sv
// SCL edge and stable-low events
`timescale 1ns/1ns
`default_nettype none

module scl_event_detect (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  output logic scl_negedge_o,
  output logic scl_posedge_o,
  output logic scl_stable_low_o
);
  logic [i3c_timing_pkg::SYNC_STAGES-1:0] sync_q;
  logic                                    scl_q;
  logic [i3c_timing_pkg::TIMING_CNT_W-1:0] low_cnt_q;
  logic                                    scl_sync;

  // Synchronised SCL level
  assign scl_sync = sync_q[i3c_timing_pkg::SYNC_STAGES-1];

  // Bus idles high, so the chain resets to 1
  always_ff @(posedge clk_i or negedge rst_ni) begin : sync_edges
    if (!rst_ni) begin
      sync_q        <= '1;
      scl_q         <= 1'b1;
      scl_negedge_o <= 1'b0;
      scl_posedge_o <= 1'b0;
    end else begin
      sync_q        <= {sync_q[i3c_timing_pkg::SYNC_STAGES-2:0], scl_i};
      scl_q         <= scl_sync;
      // Registered pulses, SYNC_STAGES+1 cycles after the pin
      scl_negedge_o <= scl_q & ~scl_sync;
      scl_posedge_o <= ~scl_q & scl_sync;
    end
  end

  // Clears together with the rising pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin : stable_low
    if (!rst_ni) begin
      low_cnt_q        <= '0;
      scl_stable_low_o <= 1'b0;
    end else if (scl_sync) begin
      low_cnt_q        <= '0;
      scl_stable_low_o <= 1'b0;
    end else if (32'(low_cnt_q) < i3c_timing_pkg::STABLE_LOW_CYCLES) begin
      low_cnt_q <= low_cnt_q + 1'b1;
    end else begin
      scl_stable_low_o <= 1'b1;
    end
  end
endmodule

`default_nettype wire

// File: logic/tx_bit_if.sv
// Flow to driver bit link
`timescale 1ns/1ns
`default_nettype none

interface tx_bit_if;
  // Bit request from the flow stage
  logic drive;
  logic drive_value;
  // 0 selects open drain, 1 push pull
  logic sel_od_pp;

  // Status back from the driver
  logic tx_idle;
  logic tx_done;
  logic setup_err;

  modport flow (output drive, drive_value, sel_od_pp,
                input  tx_idle, tx_done, setup_err);

  modport driver (input  drive, drive_value, sel_od_pp,
                  output tx_idle, tx_done, setup_err);
endinterface

`default_nettype wire

// File: verification/i3c_tx_assertions.sv
// Flow stage assertions
`timescale 1ns/1ns
`default_nettype none

module i3c_tx_assertions (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  req_byte_i,
  input logic                  req_bit_i,
  input logic                  abort_i,
  input logic                  done_i,
  input logic                  req_error_i,
  input i3c_tx_pkg::tx_state_e state_i
);
  // Request error drops the transfer and leaves the flow idle
  a_req_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_error_i |-> !done_i ##1 state_i == i3c_tx_pkg::IDLE)
    else $error("req_error_o did not return the flow stage to IDLE");

  // Done only while one request is held and a byte or a bit is on the bus
  a_done_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> ((req_byte_i ^ req_bit_i) &&
                (state_i == i3c_tx_pkg::DRIVE_BYTE || state_i == i3c_tx_pkg::DRIVE_BIT)))
    else $error("bus_tx_done_o pulsed outside a transfer");

  // Abort wins over done and leaves the flow idle
  a_abort_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    abort_i |-> !done_i ##1 state_i == i3c_tx_pkg::IDLE)
    else $error("abort_i did not return the flow stage to IDLE");
endmodule

`default_nettype wire

// File: verification/tb_i3c_tx.sv
// I3C transmit testbench
`timescale 1ns/1ns
`default_nettype none

module tb_i3c_tx;
  localparam int unsigned CLK_HALF       = 20;
  localparam int unsigned RESET_CYCLES   = 16;
  localparam int unsigned DRIVE_DELAY    = 5;
  localparam int unsigned SCL_MIN_HALF   = 12;
  localparam int unsigned SCL_SPAN       = 9;
  localparam int unsigned SHORT_LOW      = 5;
  localparam int unsigned NUM_BYTES      = 8;
  localparam int unsigned NUM_BITS       = 8;
  localparam int unsigned NUM_CHAIN      = 10;
  // Error, abort and short low requests on top
  localparam int unsigned NUM_REQ        = NUM_BYTES + NUM_BITS + NUM_CHAIN + 3;
  localparam int unsigned MAX_SCL_PERIOD = 2 * (SCL_MIN_HALF + SCL_SPAN - 1);
  localparam int unsigned WATCHDOG_CYCLES = NUM_REQ * 9 * MAX_SCL_PERIOD * 2;

  logic       clk_i;
  logic       rst_ni;
  logic       scl_i;
  logic       req_byte_i;
  logic       req_bit_i;
  logic [7:0] req_value_i;
  logic       abort_i;
  logic       sel_od_pp_i;
  logic       bus_tx_done_o;
  logic       bus_tx_idle_o;
  logic       req_error_o;
  logic       bus_error_o;
  logic       sda_o;
  logic       sel_od_pp_o;

  // SCL generator control
  bit scl_low;
  bit scl_run;
  bit short_low;
  int tb_errs;
  int test_num;
  int failed_tests;
  int err_base;

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  i3c_tx_top dut0 (.*);

  tx_checker chk0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .scl_i       (scl_i),
    .sda_i       (sda_o),
    .sel_od_pp_i (sel_od_pp_o),
    .done_i      (bus_tx_done_o),
    .bus_error_i (bus_error_o)
  );

  bind bus_tx_flow i3c_tx_assertions asrt0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_byte_i  (req_byte_i),
    .req_bit_i   (req_bit_i),
    .abort_i     (abort_i),
    .done_i      (bus_tx_done_o),
    .req_error_i (req_error_o),
    .state_i     (state_q)
  );

  // Idle high, then held low, then random half periods
  initial begin : scl_gen
    int unsigned half;
    scl_i = 1'b1;
    wait (scl_low);
    @(posedge clk_i);
    #DRIVE_DELAY scl_i = 1'b0;
    wait (scl_run);
    forever begin
      if (!scl_i && short_low) half = SHORT_LOW;
      else half = SCL_MIN_HALF + ($urandom % SCL_SPAN);
      repeat (half) @(posedge clk_i);
      #DRIVE_DELAY scl_i = ~scl_i;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      tb_errs++;
    end
  endtask

  function automatic int total_errs();
    return tb_errs + chk0.err_cnt;
  endfunction

  task automatic begin_test();
    err_base = total_errs();
    test_num++;
  endtask

  task automatic end_test(input string name);
    int n;
    n = total_errs() - err_base;
    if (n == 0) begin
      $display("Test %0d %s: ok", test_num, name);
    end else begin
      $display("Test %0d %s: %0d errors", test_num, name, n);
      failed_tests++;
    end
  endtask

  // Mid high phase, clear of pending SCL events
  task automatic sync_high();
    @(posedge scl_i);
    repeat (6) @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  // Model of the bus order, byte MSB first, single bit from bit 0
  task automatic present(input bit is_byte, input logic [7:0] val, input logic mode);
    req_byte_i  = is_byte;
    req_bit_i   = !is_byte;
    req_value_i = val;
    sel_od_pp_i = mode;
    if (is_byte) begin
      for (int i = 7; i >= 0; i--) chk0.push_bit(val[i], mode);
    end else begin
      chk0.push_bit(val[0], mode);
    end
  endtask

  task automatic drop_req();
    req_byte_i = 1'b0;
    req_bit_i  = 1'b0;
  endtask

  // Returns in the cycle after the done pulse
  task automatic wait_done();
    do @(negedge clk_i); while (bus_tx_done_o !== 1'b1);
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  task automatic settle();
    repeat (2) @(posedge scl_i);
    repeat (6) @(posedge clk_i);
    #DRIVE_DELAY;
    if (chk0.pending() != 0) begin
      $display("%0d expected bits were never seen on SDA", chk0.pending());
      tb_errs++;
    end
  endtask

  initial begin : stimulus
    int done_base;
    int berr_base;
    void'($urandom(32'h91122a9d));
    rst_ni      = 1'b0;
    req_byte_i  = 1'b0;
    req_bit_i   = 1'b0;
    req_value_i = 8'h00;
    abort_i     = 1'b0;
    sel_od_pp_i = 1'b0;
    scl_low     = 1'b0;
    scl_run     = 1'b0;
    short_low   = 1'b0;
    tb_errs      = 0;
    test_num     = 0;
    failed_tests = 0;
    err_base     = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY rst_ni = 1'b1;

    // Outputs straight after reset
    begin_test();
    @(negedge clk_i);
    check_val("sda_o", 8'd1, 8'(sda_o));
    check_val("sel_od_pp_o", 8'd0, 8'(sel_od_pp_o));
    check_val("bus_tx_done_o", 8'd0, 8'(bus_tx_done_o));
    check_val("req_error_o", 8'd0, 8'(req_error_o));
    check_val("bus_error_o", 8'd0, 8'(bus_error_o));
    scl_low = 1'b1;
    repeat (8) @(negedge clk_i);
    check_val("bus_tx_idle_o", 8'd1, 8'(bus_tx_idle_o));
    end_test("reset state");
    scl_run = 1'b1;

    begin_test();
    done_base = chk0.done_cnt;
    for (int n = 0; n < NUM_BYTES; n++) begin
      sync_high();
      present(1'b1, 8'($urandom), 1'($urandom));
      wait_done();
      drop_req();
    end
    settle();
    check_val("done count", 8'(NUM_BYTES), 8'(chk0.done_cnt - done_base));
    end_test("random bytes");

    begin_test();
    done_base = chk0.done_cnt;
    for (int n = 0; n < NUM_BITS; n++) begin
      sync_high();
      present(1'b0, 8'($urandom), 1'($urandom));
      wait_done();
      drop_req();
    end
    settle();
    check_val("done count", 8'(NUM_BITS), 8'(chk0.done_cnt - done_base));
    end_test("random bits");

    // Any released 1 between requests shifts the bit stream
    begin_test();
    done_base = chk0.done_cnt;
    sync_high();
    present(1'($urandom), 8'($urandom), 1'($urandom));
    for (int n = 1; n < NUM_CHAIN; n++) begin
      wait_done();
      present(1'($urandom), 8'($urandom), 1'($urandom));
    end
    wait_done();
    drop_req();
    settle();
    check_val("done count", 8'(NUM_CHAIN), 8'(chk0.done_cnt - done_base));
    end_test("chained requests");

    begin_test();
    sync_high();
    req_byte_i  = 1'b1;
    req_bit_i   = 1'b1;
    req_value_i = 8'($urandom);
    @(negedge clk_i);
    check_val("req_error_o", 8'd1, 8'(req_error_o));
    @(posedge clk_i);
    #DRIVE_DELAY;
    drop_req();
    settle();
    // Abort after three bits went out
    done_base = chk0.done_cnt;
    sync_high();
    present(1'b1, 8'($urandom), 1'($urandom));
    repeat (3) @(posedge scl_i);
    repeat (6) @(posedge clk_i);
    #DRIVE_DELAY;
    chk0.flush();
    // Request stays up for the rest of the byte, so only abort stops it
    abort_i = 1'b1;
    repeat (5) @(posedge scl_i);
    repeat (6) @(posedge clk_i);
    #DRIVE_DELAY;
    abort_i = 1'b0;
    drop_req();
    settle();
    check_val("done count", 8'd0, 8'(chk0.done_cnt - done_base));
    end_test("request error and abort");

    // Bits are late on purpose here, so SDA is not compared
    begin_test();
    berr_base = chk0.berr_cnt;
    chk0.set_check(1'b0);
    short_low = 1'b1;
    sync_high();
    present(1'b1, 8'($urandom), 1'b0);
    chk0.flush();
    wait_done();
    drop_req();
    short_low = 1'b0;
    repeat (2) @(posedge scl_i);
    chk0.set_check(1'b1);
    if (chk0.berr_cnt == berr_base) begin
      $display("bus_error_o never pulsed during the short SCL low phases");
      tb_errs++;
    end
    end_test("setup violation");

    $display("Tests run %0d, tests failed %0d, errors %0d", test_num, failed_tests,
             total_errs());
    if (total_errs() == 0 && failed_tests == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end
endmodule

`default_nettype wire

// File: verification/tx_checker.sv
// SDA bit monitor
`timescale 1ns/1ns
`default_nettype none

module tx_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic scl_i,
  input logic sda_i,
  input logic sel_od_pp_i,
  input logic done_i,
  input logic bus_error_i
);
  // Expected {value, mode} for each coming SCL rise
  logic [1:0] exp_q[$];
  int         err_cnt;
  int         done_cnt;
  int         berr_cnt;
  bit         check_en;

  initial begin
    err_cnt  = 0;
    done_cnt = 0;
    berr_cnt = 0;
    check_en = 1'b1;
  end

  function automatic void push_bit(input logic value, input logic mode);
    exp_q.push_back({value, mode});
  endfunction

  function automatic void flush();
    exp_q.delete();
  endfunction

  function automatic int pending();
    return exp_q.size();
  endfunction

  function automatic void set_check(input bit en);
    check_en = en;
  endfunction

  // SDA is stable at the pin rise, the driver only moves it after a fall
  always @(posedge scl_i) begin : sample_sda
    logic [1:0] exp;
    if (rst_ni && check_en) begin
      // Nothing queued means a released line, 1 in open drain
      if (exp_q.size() > 0) exp = exp_q.pop_front();
      else exp = 2'b10;
      if (sda_i !== exp[1]) begin
        $display("Fail at %0t ns: sda_o expected %b got %b", $time, exp[1], sda_i);
        err_cnt++;
      end
      if (sel_od_pp_i !== exp[0]) begin
        $display("Fail at %0t ns: sel_od_pp_o expected %b got %b", $time, exp[0], sel_od_pp_i);
        err_cnt++;
      end
    end
  end

  // Pulse counters, mid cycle where the outputs have settled
  always @(negedge clk_i) begin : count_pulses
    if (rst_ni) begin
      if (done_i) done_cnt++;
      if (bus_error_i) berr_cnt++;
    end
  end
endmodule

`default_nettype wire
